//--- rv_pkg.sv
package rv_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int STRB_W     = XLEN / 8;
	localparam int ALU_OP_W   = 4;

	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// alu operations
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd9;

	// store sizes match funct3[1:0] of SB/SH/SW
	localparam logic [1:0] SIZE_B = 2'b00;
	localparam logic [1:0] SIZE_H = 2'b01;
	localparam logic [1:0] SIZE_W = 2'b10;

	// fetch sequencer states
	localparam int IFU_ST_W = 2;
	localparam logic [IFU_ST_W-1:0] IFU_ADDR = 2'd0;
	localparam logic [IFU_ST_W-1:0] IFU_DATA = 2'd1;
	localparam logic [IFU_ST_W-1:0] IFU_EXEC = 2'd2;
	localparam logic [IFU_ST_W-1:0] IFU_WAIT = 2'd3;

	// one instruction word in four field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic [19:0] imm;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} u;
	} inst_u;

endpackage

//--- rv_ifu.sv
`timescale 1ns/1ps
module rv_ifu import rv_pkg::*; (
	input  logic            clock,
	input  logic            rst_n_i,
	output logic [XLEN-1:0] inst_addr_o,
	output logic            inst_addr_valid_o,
	input  logic            inst_addr_ready_i,
	input  logic [XLEN-1:0] inst_data_i,
	input  logic            inst_data_valid_i,
	output logic            inst_data_ready_o,
	input  logic            lsu_busy_i,
	output logic            issue_o,
	output inst_u           inst_o
);

	logic [IFU_ST_W-1:0] state_q;
	logic [IFU_ST_W-1:0] state_d;
	logic [XLEN-1:0]     pc_q;
	logic                addr_fire;
	logic                data_fire;
	logic                retire;

	assign addr_fire = inst_addr_valid_o && inst_addr_ready_i;
	assign data_fire = inst_data_ready_o && inst_data_valid_i;
	// instruction is done once any store has left the core
	assign retire    = (state_q == IFU_WAIT) && !lsu_busy_i;

	assign inst_addr_o = pc_q;
	assign issue_o     = (state_q == IFU_EXEC);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IFU_ADDR: if (addr_fire) state_d = IFU_DATA;
			IFU_DATA: if (data_fire) state_d = IFU_EXEC;
			IFU_EXEC: state_d = IFU_WAIT;
			IFU_WAIT: if (retire) state_d = IFU_ADDR;
			default:  state_d = IFU_ADDR;
		endcase
	end

	// handshake outputs follow the next state
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q           <= IFU_ADDR;
			inst_addr_valid_o <= 1'b0;
			inst_data_ready_o <= 1'b0;
			pc_q              <= RESET_PC;
		end else begin
			state_q           <= state_d;
			inst_addr_valid_o <= (state_d == IFU_ADDR);
			inst_data_ready_o <= (state_d == IFU_DATA);
			if (retire) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (data_fire) begin
			inst_o <= inst_data_i;
		end
	end

endmodule

//--- rv_idu.sv
`timescale 1ns/1ps
module rv_idu import rv_pkg::*; (
	input  inst_u                 inst_i,
	input  logic                  issue_i,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	output logic [REG_ADDR_W-1:0] rd_addr_o,
	output logic [XLEN-1:0]       imm_o,
	output logic [ALU_OP_W-1:0]   alu_op_o,
	output logic                  use_imm_o,
	output logic                  reg_wen_o,
	output logic                  store_req_o,
	output logic [1:0]            store_size_o
);

	logic [2:0] funct3;
	logic       is_op;
	logic       is_op_imm;
	logic       is_lui;
	logic       is_store;
	logic       alu_ok;
	logic       store_ok;

	assign funct3    = inst_i.r.funct3;
	assign is_op     = (inst_i.r.opcode == OPC_OP);
	assign is_op_imm = (inst_i.r.opcode == OPC_OP_IMM);
	assign is_lui    = (inst_i.r.opcode == OPC_LUI);
	assign is_store  = (inst_i.r.opcode == OPC_STORE);

	assign rs1_addr_o = inst_i.r.rs1;
	assign rs2_addr_o = inst_i.s.rs2;
	assign rd_addr_o  = inst_i.r.rd;

	// immediate per format
	always_comb begin
		case (inst_i.r.opcode)
			OPC_OP_IMM: imm_o = {{(XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
			OPC_STORE:  imm_o = {{(XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi,
				inst_i.s.imm_lo};
			OPC_LUI:    imm_o = {inst_i.u.imm, 12'b0};
			default:    imm_o = '0;
		endcase
	end

	// funct7[5] is imm[10] in the I view and picks srai the same way
	always_comb begin
		alu_op_o = ALU_ADD;
		alu_ok   = 1'b1;
		if (is_lui) begin
			alu_op_o = ALU_PASS_B;
		end else if (is_op || is_op_imm) begin
			case (funct3)
				3'b000:  alu_op_o = (is_op && inst_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001:  alu_op_o = ALU_SLL;
				3'b010:  alu_op_o = ALU_SLT;
				3'b100:  alu_op_o = ALU_XOR;
				3'b101:  alu_op_o = inst_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110:  alu_op_o = ALU_OR;
				3'b111:  alu_op_o = ALU_AND;
				// sltu/sltiu have no alu op here and retire as a nop
				default: alu_ok = 1'b0;
			endcase
		end
	end

	// only sb, sh, sw
	assign store_ok = is_store && !funct3[2] && (funct3[1:0] != 2'b11);

	assign use_imm_o    = !is_op;
	assign store_size_o = funct3[1:0];
	assign store_req_o  = issue_i && store_ok;
	assign reg_wen_o    = issue_i && (is_lui || ((is_op || is_op_imm) && alu_ok))
		&& (inst_i.r.rd != '0);

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps
module rv_regfile import rv_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	output logic [XLEN-1:0]       rs1_data_o,
	output logic [XLEN-1:0]       rs2_data_o,
	input  logic                  wen_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic [XLEN-1:0]       rd_data_i
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && (rd_addr_i != '0)) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	// x0 reads zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- rv_exu.sv
`timescale 1ns/1ps
module rv_exu import rv_pkg::*; (
	input  logic [XLEN-1:0]     rs1_data_i,
	input  logic [XLEN-1:0]     rs2_data_i,
	input  logic [XLEN-1:0]     imm_i,
	input  logic [ALU_OP_W-1:0] alu_op_i,
	input  logic                use_imm_i,
	output logic [XLEN-1:0]     result_o
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [4:0]      shamt;

	assign op_a  = rs1_data_i;
	assign op_b  = use_imm_i ? imm_i : rs2_data_i;
	assign shamt = op_b[4:0];

	// also the store address for sb/sh/sw
	always_comb begin
		case (alu_op_i)
			ALU_ADD:    result_o = op_a + op_b;
			ALU_SUB:    result_o = op_a - op_b;
			ALU_AND:    result_o = op_a & op_b;
			ALU_OR:     result_o = op_a | op_b;
			ALU_XOR:    result_o = op_a ^ op_b;
			ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			ALU_SLL:    result_o = op_a << shamt;
			ALU_SRL:    result_o = op_a >> shamt;
			ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
			ALU_PASS_B: result_o = op_b;
			default:    result_o = '0;
		endcase
	end

endmodule

//--- rv_lsu.sv
`timescale 1ns/1ps
module rv_lsu import rv_pkg::*; (
	input  logic              clock,
	input  logic              rst_n_i,
	input  logic              store_req_i,
	input  logic [1:0]        store_size_i,
	input  logic [XLEN-1:0]   addr_i,
	input  logic [XLEN-1:0]   store_data_i,
	output logic [XLEN-1:0]   data_w_addr_o,
	output logic [XLEN-1:0]   data_w_data_o,
	output logic [STRB_W-1:0] data_w_strb_o,
	output logic              data_w_valid_o,
	input  logic              data_w_ready_i,
	output logic              busy_o
);

	logic [XLEN-1:0]   lane_data;
	logic [STRB_W-1:0] lane_strb;

	// replicate into every lane and let the strobe pick the live one
	always_comb begin
		case (store_size_i)
			SIZE_B: begin
				lane_data = {4{store_data_i[7:0]}};
				lane_strb = 4'b0001 << addr_i[1:0];
			end
			SIZE_H: begin
				lane_data = {2{store_data_i[15:0]}};
				lane_strb = addr_i[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				lane_data = store_data_i;
				lane_strb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			data_w_valid_o <= 1'b0;
		end else if (store_req_i) begin
			data_w_valid_o <= 1'b1;
		end else if (data_w_ready_i) begin
			data_w_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (store_req_i) begin
			data_w_addr_o <= {addr_i[XLEN-1:2], 2'b00};
			data_w_data_o <= lane_data;
			data_w_strb_o <= lane_strb;
		end
	end

	assign busy_o = data_w_valid_o;

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
module rv_core import rv_pkg::*; (
	input  logic              clock,
	input  logic              rst_n_i,
	output logic [XLEN-1:0]   inst_addr_o,
	output logic              inst_addr_valid_o,
	input  logic              inst_addr_ready_i,
	input  logic [XLEN-1:0]   inst_data_i,
	input  logic              inst_data_valid_i,
	output logic              inst_data_ready_o,
	output logic [XLEN-1:0]   data_w_addr_o,
	output logic [XLEN-1:0]   data_w_data_o,
	output logic [STRB_W-1:0] data_w_strb_o,
	output logic              data_w_valid_o,
	input  logic              data_w_ready_i
);

	inst_u                 inst;
	logic                  issue;
	logic                  lsu_busy;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic [XLEN-1:0]       imm;
	logic [ALU_OP_W-1:0]   alu_op;
	logic                  use_imm;
	logic                  reg_wen;
	logic                  store_req;
	logic [1:0]            store_size;
	logic [XLEN-1:0]       alu_result;

	rv_ifu u_ifu (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.inst_addr_o       (inst_addr_o),
		.inst_addr_valid_o (inst_addr_valid_o),
		.inst_addr_ready_i (inst_addr_ready_i),
		.inst_data_i       (inst_data_i),
		.inst_data_valid_i (inst_data_valid_i),
		.inst_data_ready_o (inst_data_ready_o),
		.lsu_busy_i        (lsu_busy),
		.issue_o           (issue),
		.inst_o            (inst)
	);

	rv_idu u_idu (
		.inst_i       (inst),
		.issue_i      (issue),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rd_addr_o    (rd_addr),
		.imm_o        (imm),
		.alu_op_o     (alu_op),
		.use_imm_o    (use_imm),
		.reg_wen_o    (reg_wen),
		.store_req_o  (store_req),
		.store_size_o (store_size)
	);

	rv_regfile u_regfile (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wen_i      (reg_wen),
		.rd_addr_i  (rd_addr),
		.rd_data_i  (alu_result)
	);

	rv_exu u_exu (
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.imm_i      (imm),
		.alu_op_i   (alu_op),
		.use_imm_i  (use_imm),
		.result_o   (alu_result)
	);

	// store address comes from the alu and data straight from rs2
	rv_lsu u_lsu (
		.clock          (clock),
		.rst_n_i        (rst_n_i),
		.store_req_i    (store_req),
		.store_size_i   (store_size),
		.addr_i         (alu_result),
		.store_data_i   (rs2_data),
		.data_w_addr_o  (data_w_addr_o),
		.data_w_data_o  (data_w_data_o),
		.data_w_strb_o  (data_w_strb_o),
		.data_w_valid_o (data_w_valid_o),
		.data_w_ready_i (data_w_ready_i),
		.busy_o         (lsu_busy)
	);

endmodule

//--- rv_core_sva.sv
`timescale 1ns/1ps
module rv_core_sva import rv_pkg::*; (
	input logic              clock,
	input logic              rst_n_i,
	input logic [XLEN-1:0]   inst_addr_o,
	input logic              inst_addr_valid_o,
	input logic              inst_addr_ready_i,
	input logic              inst_data_ready_o,
	input logic [XLEN-1:0]   data_w_addr_o,
	input logic [XLEN-1:0]   data_w_data_o,
	input logic [STRB_W-1:0] data_w_strb_o,
	input logic              data_w_valid_o,
	input logic              data_w_ready_i
);

	// fetch request held under back-pressure
	addr_hold_a: assert property (@(posedge clock) disable iff (!rst_n_i)
		inst_addr_valid_o && !inst_addr_ready_i |=> inst_addr_valid_o && $stable(inst_addr_o))
	else $error("instruction address dropped or changed before acceptance");

	// write request held with its payload until ready
	write_hold_a: assert property (@(posedge clock) disable iff (!rst_n_i)
		data_w_valid_o && !data_w_ready_i |=> data_w_valid_o && $stable(data_w_addr_o)
		&& $stable(data_w_data_o) && $stable(data_w_strb_o))
	else $error("data write dropped or changed before acceptance");

	reset_quiet_a: assert property (@(posedge clock)
		!rst_n_i |-> !inst_addr_valid_o && !inst_data_ready_o && !data_w_valid_o)
	else $error("handshake output high during reset");

endmodule

bind rv_core rv_core_sva u_sva (.*);

//--- tb_rv_core.sv
`timescale 1ns/1ps
module tb_rv_core import rv_pkg::*; ();

	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 5;
	localparam int MEM_AW          = 6;
	localparam int MEM_WORDS       = 1 << MEM_AW;
	localparam int NUM_TESTS       = 5;
	localparam int MAX_TEST_CYCLES = 4000;

	logic              clock             = 1'b0;
	logic              rst_n_i           = 1'b0;
	logic              inst_addr_ready_i = 1'b0;
	logic [XLEN-1:0]   inst_data_i       = '0;
	logic              inst_data_valid_i = 1'b0;
	logic              data_w_ready_i    = 1'b0;
	logic [XLEN-1:0]   inst_addr_o;
	logic              inst_addr_valid_o;
	logic              inst_data_ready_o;
	logic [XLEN-1:0]   data_w_addr_o;
	logic [XLEN-1:0]   data_w_data_o;
	logic [STRB_W-1:0] data_w_strb_o;
	logic              data_w_valid_o;

	logic [XLEN-1:0]   imem [MEM_WORDS];
	logic [XLEN-1:0]   model_regs [NUM_REGS];
	logic [XLEN-1:0]   exp_addr [$];
	logic [XLEN-1:0]   exp_data [$];
	logic [STRB_W-1:0] exp_strb [$];
	logic [XLEN-1:0]   got_addr [$];
	logic [XLEN-1:0]   got_data [$];
	logic [STRB_W-1:0] got_strb [$];
	int                prog_len      = 0;
	int                seed          = 32'h7246;
	logic              stall_en      = 1'b0;
	logic              a_fire        = 1'b0;
	logic              d_fire        = 1'b0;
	logic              have_addr     = 1'b0;
	logic              drive_idle    = 1'b1;
	logic [XLEN-1:0]   fetch_addr    = '0;
	logic [XLEN-1:0]   first_fetch   = '0;
	int                fetch_cnt     = 0;
	int                error_cnt     = 0;
	int                test_errs     = 0;
	int                test_cnt      = 0;
	int                test_fail_cnt = 0;
	string             test_name     = "none";

	rv_core u_dut (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.inst_addr_o       (inst_addr_o),
		.inst_addr_valid_o (inst_addr_valid_o),
		.inst_addr_ready_i (inst_addr_ready_i),
		.inst_data_i       (inst_data_i),
		.inst_data_valid_i (inst_data_valid_i),
		.inst_data_ready_o (inst_data_ready_o),
		.data_w_addr_o     (data_w_addr_o),
		.data_w_data_o     (data_w_data_o),
		.data_w_strb_o     (data_w_strb_o),
		.data_w_valid_o    (data_w_valid_o),
		.data_w_ready_i    (data_w_ready_i)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic logic ready_draw();
		if (!stall_en) begin
			return 1'b1;
		end
		return (($random(seed) & 3) == 0);
	endfunction

	// handshakes seen mid-cycle complete at the next rising edge
	always @(negedge clock) begin
		a_fire = 1'b0;
		d_fire = 1'b0;
		if (rst_n_i) begin
			if (inst_addr_valid_o && inst_addr_ready_i) begin
				a_fire     = 1'b1;
				fetch_addr = inst_addr_o;
				if (fetch_cnt == 0) begin
					first_fetch = inst_addr_o;
				end
				if (inst_addr_o !== RESET_PC + 4 * fetch_cnt) begin
					$display("Fail %s fetch %0d address expected %h actual %h", test_name,
						fetch_cnt, RESET_PC + 4 * fetch_cnt, inst_addr_o);
					error_cnt++;
				end
				fetch_cnt++;
			end
			d_fire = inst_data_valid_i && inst_data_ready_o;
			if (data_w_valid_o && data_w_ready_i) begin
				got_addr.push_back(data_w_addr_o);
				got_data.push_back(data_w_data_o);
				got_strb.push_back(data_w_strb_o);
			end
		end
	end

	// instruction memory and write-ready driver
	always @(posedge clock) begin
		drive_idle = !rst_n_i;
		#1;
		if (drive_idle) begin
			inst_addr_ready_i = 1'b0;
			inst_data_valid_i = 1'b0;
			data_w_ready_i    = 1'b0;
			have_addr         = 1'b0;
		end else begin
			if (d_fire) begin
				inst_data_valid_i = 1'b0;
				have_addr         = 1'b0;
			end
			if (a_fire) begin
				have_addr   = 1'b1;
				inst_data_i = imem[MEM_AW'((fetch_addr - RESET_PC) >> 2)];
			end
			if (have_addr && !inst_data_valid_i) begin
				inst_data_valid_i = ready_draw();
			end
			inst_addr_ready_i = ready_draw();
			data_w_ready_i    = ready_draw();
		end
	end

	initial begin
		#(NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD);
		$display("Error: the run did not finish within the watchdog limit");
		$display("*** FAILED ***");
		$finish;
	end

	function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			3'b100:  return a ^ b;
			3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic put_inst(input logic [XLEN-1:0] word);
		imem[MEM_AW'(prog_len)] = word;
		prog_len++;
	endtask

	task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		put_inst({imm, rs1, f3, rd, OPC_OP_IMM});
		if (rd != 5'd0) begin
			model_regs[rd] = alu_ref(f3, (f3 == 3'b101) && imm[10], model_regs[rs1],
				{{20{imm[11]}}, imm});
		end
	endtask

	task automatic op_reg(input logic alt, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		put_inst({alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_OP});
		if (rd != 5'd0) begin
			model_regs[rd] = alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]);
		end
	endtask

	task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
		put_inst({imm, rd, OPC_LUI});
		if (rd != 5'd0) begin
			model_regs[rd] = {imm, 12'b0};
		end
	endtask

	// expected write follows the strobe and lane rules of the data port
	task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   val;
		logic [XLEN-1:0]   data;
		logic [STRB_W-1:0] strb;
		put_inst({imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE});
		addr = model_regs[rs1] + {{20{imm[11]}}, imm};
		val  = model_regs[rs2];
		// lane b carries data bits 8b+7 to 8b
		for (int b = 0; b < STRB_W; b++) begin
			case (f3[1:0])
				2'b00: begin
					strb[b]        = (b == int'(addr[1:0]));
					data[8*b +: 8] = val[7:0];
				end
				2'b01: begin
					strb[b]        = ((b / 2) == int'(addr[1]));
					data[8*b +: 8] = val[8*(b % 2) +: 8];
				end
				default: begin
					strb[b]        = 1'b1;
					data[8*b +: 8] = val[8*b +: 8];
				end
			endcase
		end
		exp_addr.push_back({addr[XLEN-1:2], 2'b00});
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	task automatic store_reg(input logic [4:0] rd);
		store(3'b010, rd, 5'd0, {5'b0, rd, 2'b00});
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [XLEN-1:0] v);
		lui(rd, 20'((v + 32'h800) >> 12));
		op_imm(3'b000, rd, rd, v[11:0]);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = error_cnt;
		test_cnt++;
		prog_len  = 0;
		// addi x0, x0, index is a nop that still marks its own address
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[MEM_AW'(i)] = {12'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[5'(i)] = '0;
		end
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
	endtask

	task automatic end_test();
		if (error_cnt == test_errs) begin
			$display("test %s ok", test_name);
		end else begin
			$display("test %s failed with %0d errors", test_name, error_cnt - test_errs);
			test_fail_cnt++;
		end
	endtask

	task automatic apply_reset();
		rst_n_i   = 1'b0;
		fetch_cnt = 0;
		got_addr.delete();
		got_data.delete();
		got_strb.delete();
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			if (inst_addr_valid_o || inst_data_ready_o || data_w_valid_o) begin
				$display("Error %s: a handshake output is high during reset", test_name);
				error_cnt++;
			end
		end
		@(posedge clock);
		#1;
		rst_n_i = 1'b1;
	endtask

	// the fetch after the last instruction means everything has retired
	task automatic run_prog();
		int n;
		n = prog_len;
		apply_reset();
		while (fetch_cnt <= n) begin
			@(negedge clock);
		end
	endtask

	task automatic check_val(input string what, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
			error_cnt++;
		end
	endtask

	task automatic check_stores();
		if (got_data.size() != exp_data.size()) begin
			$display("Fail %s store count expected %0d actual %0d", test_name,
				exp_data.size(), got_data.size());
			error_cnt++;
		end else begin
			foreach (exp_data[i]) begin
				check_val($sformatf("store %0d addr", i), exp_addr[i], got_addr[i]);
				check_val($sformatf("store %0d data", i), exp_data[i], got_data[i]);
				check_val($sformatf("store %0d strb", i), 32'(exp_strb[i]), 32'(got_strb[i]));
			end
		end
	endtask

	task automatic reset_test();
		start_test("reset");
		op_imm(3'b000, 5'd1, 5'd0, 12'h005);
		store_reg(5'd1);
		run_prog();
		check_val("first fetch", RESET_PC, first_fetch);
		check_stores();
		end_test();
	endtask

	task automatic imm_test();
		start_test("imm_alu");
		lui(5'd1, 20'h12345);
		store_reg(5'd1);
		op_imm(3'b000, 5'd2, 5'd1, 12'h678);
		store_reg(5'd2);
		op_imm(3'b111, 5'd3, 5'd1, 12'hf0f);
		store_reg(5'd3);
		op_imm(3'b110, 5'd4, 5'd1, 12'h0f0);
		store_reg(5'd4);
		op_imm(3'b100, 5'd5, 5'd1, 12'h800);
		store_reg(5'd5);
		op_imm(3'b010, 5'd6, 5'd1, 12'h7ff);
		store_reg(5'd6);
		op_imm(3'b010, 5'd7, 5'd5, 12'h001);
		store_reg(5'd7);
		op_imm(3'b001, 5'd8, 5'd1, 12'h004);
		store_reg(5'd8);
		op_imm(3'b101, 5'd9, 5'd5, 12'h008);
		store_reg(5'd9);
		op_imm(3'b101, 5'd10, 5'd5, 12'h408);
		store_reg(5'd10);
		run_prog();
		check_stores();
		end_test();
	endtask

	task automatic reg_op_store(input logic alt, input logic [2:0] f3, input logic [4:0] rd);
		op_reg(alt, f3, rd, 5'd1, 5'd2);
		store_reg(rd);
	endtask

	task automatic reg_test();
		logic [XLEN-1:0] va;
		logic [XLEN-1:0] vb;
		start_test("reg_alu");
		va = $random(seed);
		vb = $random(seed);
		// negative a and a shift of 16 or more keep sra apart from srl
		va[XLEN-1] = 1'b1;
		vb[4]      = 1'b1;
		load_const(5'd1, va);
		load_const(5'd2, vb);
		reg_op_store(1'b0, 3'b000, 5'd3);
		reg_op_store(1'b1, 3'b000, 5'd4);
		reg_op_store(1'b0, 3'b111, 5'd5);
		reg_op_store(1'b0, 3'b110, 5'd6);
		reg_op_store(1'b0, 3'b100, 5'd7);
		reg_op_store(1'b0, 3'b010, 5'd8);
		reg_op_store(1'b0, 3'b001, 5'd9);
		reg_op_store(1'b0, 3'b101, 5'd10);
		reg_op_store(1'b1, 3'b101, 5'd11);
		// x0 stays zero after a write
		reg_op_store(1'b0, 3'b000, 5'd0);
		run_prog();
		check_stores();
		end_test();
	endtask

	task automatic narrow_test();
		start_test("narrow_store");
		load_const(5'd1, $random(seed));
		for (int off = 0; off < 4; off++) begin
			store(3'b000, 5'd1, 5'd0, 12'h080 | 12'(off));
		end
		store(3'b001, 5'd1, 5'd0, 12'h0c0);
		store(3'b001, 5'd1, 5'd0, 12'h0c2);
		run_prog();
		check_stores();
		end_test();
	endtask

	task automatic stall_test();
		start_test("stall");
		load_const(5'd1, $random(seed));
		load_const(5'd2, $random(seed));
		op_reg(1'b0, 3'b000, 5'd3, 5'd1, 5'd2);
		store(3'b000, 5'd3, 5'd0, 12'h101);
		// lw x3 is unsupported and leaves x3 as it was
		put_inst({12'h000, 5'd0, 3'b010, 5'd3, 7'b0000011});
		store_reg(5'd3);
		store(3'b001, 5'd2, 5'd0, 12'h142);
		op_imm(3'b100, 5'd4, 5'd3, 12'h5a5);
		store_reg(5'd4);
		stall_en = 1'b0;
		run_prog();
		check_stores();
		stall_en = 1'b1;
		run_prog();
		check_stores();
		stall_en = 1'b0;
		end_test();
	endtask

	initial begin
		reset_test();
		imm_test();
		reg_test();
		narrow_test();
		stall_test();
		$display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- rv_core.f
rv_pkg.sv
rv_ifu.sv
rv_idu.sv
rv_regfile.sv
rv_exu.sv
rv_lsu.sv
rv_core.sv
rv_core_sva.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f -o Vtb_rv_core
./obj_dir/Vtb_rv_core | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
